/* rob_pkg.sv */
package rob_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // widest rob index carried in packets, 64 entries
    localparam int ROB_ID_MAX_W = 6;
    localparam int XLEN = 32;

    //////////////////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_LOAD   = 2'd1,
        KIND_STORE  = 2'd2,
        KIND_BRANCH = 2'd3
    } inst_kind_e;

    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_ADEF = 3'd1,
        EXC_ALE  = 3'd2,
        EXC_SYS  = 3'd3,
        EXC_BRK  = 3'd4,
        EXC_INE  = 3'd5
    } exc_code_e;

    //////////////////////////////////////////////////////////////////////
    // packets and table entries
    //////////////////////////////////////////////////////////////////////

    // one instruction from the dispatch side
    typedef struct packed {
        logic                         issue;
        logic [ROB_ID_MAX_W-1:0]      rob_id;
        logic [1:0][ROB_ID_MAX_W-1:0] src_id;
        logic [4:0]                   areg;
        logic                         w_reg;
        logic                         w_mem;
        inst_kind_e                   kind;
        logic [XLEN-1:0]              pc;
        logic [15:0]                  addr_imm;
    } dispatch_pkt_t;

    // one result on a cdb
    typedef struct packed {
        logic                    w_valid;
        logic [ROB_ID_MAX_W-1:0] w_preg;
        logic [XLEN-1:0]         w_data;
        exc_code_e               exc;
    } cdb_pkt_t;

    typedef struct packed {
        logic [4:0]      areg;
        logic            w_reg;
        logic            w_mem;
        inst_kind_e      kind;
        logic [XLEN-1:0] pc;
        logic [15:0]     addr_imm;
    } rob_inst_entry_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        exc_code_e       exc;
    } rob_data_entry_t;

    // source operands of one dispatched instruction
    typedef struct packed {
        logic [1:0][XLEN-1:0] data;
        logic [1:0]           done;
    } rob_operand_t;

    typedef struct packed {
        logic [ROB_ID_MAX_W-1:0] rob_id;
        rob_inst_entry_t         inst;
        rob_data_entry_t         data;
    } commit_cand_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            arf_we;
        logic [4:0]      arf_id;
        logic [XLEN-1:0] arf_data;
        logic            mem_commit;
        exc_code_e       exc;
    } retire_t;

endpackage

/* rob_regfile.sv */
module rob_regfile #(
    parameter int DATA_W  = 32,
    parameter int DEPTH   = 64,
    parameter int R_PORTS = 2,
    parameter int W_PORTS = 2
) (
    input  logic                                          clk,
    input  logic [R_PORTS-1:0][$clog2(DEPTH)-1:0]         raddr_i,
    output logic [R_PORTS-1:0][DATA_W-1:0]                rdata_o,
    input  logic [W_PORTS-1:0][$clog2(DEPTH)-1:0]         waddr_i,
    input  logic [W_PORTS-1:0][DATA_W-1:0]                wdata_i,
    input  logic [W_PORTS-1:0]                            we_i
);

    localparam int ADDR_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem_q [DEPTH];
    logic [DATA_W-1:0] mem_d [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    // per entry next value, later ports override earlier ones
    always_comb begin
        for (int e = 0; e < DEPTH; e++) begin
            mem_d[e] = mem_q[e];
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w] && (waddr_i[w] == ADDR_W'(e))) begin
                    mem_d[e] = wdata_i[w];
                end
            end
        end
    end

    // storage only, contents are kept across flush
    always_ff @(posedge clk) begin
        for (int e = 0; e < DEPTH; e++) begin
            mem_q[e] <= mem_d[e];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    // asynchronous reads, old value when written in the same cycle
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem_q[raddr_i[r]];
        end
    end

endmodule

/* rob_done_table.sv */
module rob_done_table #(
    parameter int ROB_DEPTH_LOG2 = 6
) (
    input  logic                           clk,
    input  logic [1:0]                     disp_we_i,
    input  logic [1:0][ROB_DEPTH_LOG2-1:0] disp_id_i,
    input  logic [1:0]                     cdb_we_i,
    input  logic [1:0][ROB_DEPTH_LOG2-1:0] cdb_id_i,
    input  logic [5:0][ROB_DEPTH_LOG2-1:0] query_id_i,
    output logic [5:0]                     done_o
);

    localparam int DEPTH = 1 << ROB_DEPTH_LOG2;

    // read ports 5..0 serve queries, 7..6 serve the opposite writer
    logic [7:0] disp_rd;
    logic [7:0] cdb_rd;
    logic [1:0] disp_wdata;
    logic [1:0] cdb_wdata;

    //////////////////////////////////////////////////////////////////////
    // toggle bits
    //////////////////////////////////////////////////////////////////////

    // dispatch copies the cdb bit, so the pair reads equal, not done
    assign disp_wdata = cdb_rd[7:6];

    // cdb writes the inverse of the dispatch bit, pair reads different
    assign cdb_wdata = ~disp_rd[7:6];

    rob_regfile #(
        .DATA_W  (1),
        .DEPTH   (DEPTH),
        .R_PORTS (8),
        .W_PORTS (2)
    ) u_disp_table (
        .clk     (clk),
        .raddr_i ({cdb_id_i, query_id_i}),
        .rdata_o (disp_rd),
        .waddr_i (disp_id_i),
        .wdata_i (disp_wdata),
        .we_i    (disp_we_i)
    );

    rob_regfile #(
        .DATA_W  (1),
        .DEPTH   (DEPTH),
        .R_PORTS (8),
        .W_PORTS (2)
    ) u_cdb_table (
        .clk     (clk),
        .raddr_i ({disp_id_i, query_id_i}),
        .rdata_o (cdb_rd),
        .waddr_i (cdb_id_i),
        .wdata_i (cdb_wdata),
        .we_i    (cdb_we_i)
    );

    //////////////////////////////////////////////////////////////////////
    // queries
    //////////////////////////////////////////////////////////////////////

    // complete when the two bits differ
    assign done_o = disp_rd[5:0] ^ cdb_rd[5:0];

endmodule

/* rob.sv */
module rob
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH_LOG2 = 6
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      flush_i,
    input  dispatch_pkt_t [1:0]       dispatch_i,
    input  cdb_pkt_t      [1:0]       cdb_i,
    input  logic          [1:0]       commit_req_i,
    output rob_operand_t  [1:0]       operand_o,
    output logic [ROB_DEPTH_LOG2:0]   count_o,
    output commit_cand_t  [1:0]       cand_o,
    output logic          [1:0]       commit_valid_o
);

    localparam int DEPTH = 1 << ROB_DEPTH_LOG2;
    localparam int PTR_W = ROB_DEPTH_LOG2;
    localparam int CNT_W = ROB_DEPTH_LOG2 + 1;

    //////////////////////////////////////////////////////////////////////
    // tail pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    // tail_q[0] is the oldest entry, tail_q[1] the one after it
    logic [1:0][PTR_W-1:0] tail_q;
    logic [CNT_W-1:0]      count_q;
    logic [CNT_W-1:0]      count_d;
    logic [1:0]            issue;
    logic [1:0]            n_disp;
    logic [1:0]            n_commit;

    assign issue    = {dispatch_i[1].issue, dispatch_i[0].issue};
    assign n_disp   = {1'b0, issue[0]} + {1'b0, issue[1]};
    assign n_commit = {1'b0, commit_req_i[0]} + {1'b0, commit_req_i[1]};
    assign count_d  = count_q + CNT_W'(n_disp) - CNT_W'(n_commit);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tail_q  <= {PTR_W'(1), PTR_W'(0)};
            count_q <= '0;
        end else if (flush_i) begin
            // flush drops every entry, tables keep their contents
            tail_q  <= {PTR_W'(1), PTR_W'(0)};
            count_q <= '0;
        end else begin
            tail_q[0] <= tail_q[0] + PTR_W'(n_commit);
            tail_q[1] <= tail_q[1] + PTR_W'(n_commit);
            count_q   <= count_d;
        end
    end

    assign count_o = count_q;

    //////////////////////////////////////////////////////////////////////
    // table write data
    //////////////////////////////////////////////////////////////////////

    rob_inst_entry_t [1:0]            disp_inst;
    logic            [1:0][PTR_W-1:0] disp_id;
    rob_data_entry_t [1:0]            cdb_data;
    logic            [1:0][PTR_W-1:0] cdb_id;
    logic            [1:0]            cdb_we;
    logic            [3:0][PTR_W-1:0] src_id;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            disp_inst[i].areg     = dispatch_i[i].areg;
            disp_inst[i].w_reg    = dispatch_i[i].w_reg;
            disp_inst[i].w_mem    = dispatch_i[i].w_mem;
            disp_inst[i].kind     = dispatch_i[i].kind;
            disp_inst[i].pc       = dispatch_i[i].pc;
            disp_inst[i].addr_imm = dispatch_i[i].addr_imm;
            disp_id[i]            = dispatch_i[i].rob_id[PTR_W-1:0];

            cdb_data[i].data = cdb_i[i].w_data;
            cdb_data[i].exc  = cdb_i[i].exc;
            cdb_id[i]        = cdb_i[i].w_preg[PTR_W-1:0];
            cdb_we[i]        = cdb_i[i].w_valid;

            // source j of instruction i sits at 2*i+j
            src_id[2*i]   = dispatch_i[i].src_id[0][PTR_W-1:0];
            src_id[2*i+1] = dispatch_i[i].src_id[1][PTR_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tables
    //////////////////////////////////////////////////////////////////////

    rob_inst_entry_t [1:0] inst_rd;
    rob_data_entry_t [5:0] data_rd;
    logic            [5:0] done;

    rob_regfile #(
        .DATA_W  ($bits(rob_inst_entry_t)),
        .DEPTH   (DEPTH),
        .R_PORTS (2),
        .W_PORTS (2)
    ) u_inst_table (
        .clk     (clk),
        .raddr_i (tail_q),
        .rdata_o (inst_rd),
        .waddr_i (disp_id),
        .wdata_i (disp_inst),
        .we_i    (issue)
    );

    // ports 3..0 for sources, 5..4 for the two oldest entries
    rob_regfile #(
        .DATA_W  ($bits(rob_data_entry_t)),
        .DEPTH   (DEPTH),
        .R_PORTS (6),
        .W_PORTS (2)
    ) u_data_table (
        .clk     (clk),
        .raddr_i ({tail_q, src_id}),
        .rdata_o (data_rd),
        .waddr_i (cdb_id),
        .wdata_i (cdb_data),
        .we_i    (cdb_we)
    );

    rob_done_table #(
        .ROB_DEPTH_LOG2 (ROB_DEPTH_LOG2)
    ) u_done_table (
        .clk        (clk),
        .disp_we_i  (issue),
        .disp_id_i  (disp_id),
        .cdb_we_i   (cdb_we),
        .cdb_id_i   (cdb_id),
        .query_id_i ({tail_q, src_id}),
        .done_o     (done)
    );

    //////////////////////////////////////////////////////////////////////
    // operand reads and commit candidates
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            operand_o[i].data[0] = data_rd[2*i].data;
            operand_o[i].data[1] = data_rd[2*i+1].data;
            operand_o[i].done    = done[2*i+1 -: 2];

            cand_o[i].rob_id = ROB_ID_MAX_W'(tail_q[i]);
            cand_o[i].inst   = inst_rd[i];
            cand_o[i].data   = data_rd[4+i];
        end
    end

    // slot valid only when the entry is complete and actually occupied
    assign commit_valid_o[0] = done[4] & (count_q != '0);
    assign commit_valid_o[1] = done[5] & (count_q > CNT_W'(1));

endmodule

/* rob_commit.sv */
module rob_commit
    import rob_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n_i,
    input  commit_cand_t [1:0] cand_i,
    input  logic         [1:0] commit_valid_i,
    output logic         [1:0] commit_req_o,
    output retire_t      [1:0] retire_o,
    output logic               flush_o
);

    logic          flush_q;
    logic          flush_d;
    logic    [1:0] req;
    logic    [1:0] no_exc;
    retire_t [1:0] retire_d;
    retire_t [1:0] retire_q;

    assign no_exc[0] = (cand_i[0].data.exc == EXC_NONE);
    assign no_exc[1] = (cand_i[1].data.exc == EXC_NONE);

    //////////////////////////////////////////////////////////////////////
    // retirement decision
    //////////////////////////////////////////////////////////////////////

    // in order: slot 1 only behind a clean slot 0, nothing while flushing
    always_comb begin
        req = '0;
        if (!flush_q) begin
            req[0] = commit_valid_i[0];
            req[1] = commit_valid_i[0] & commit_valid_i[1] & no_exc[0];
        end
    end

    assign commit_req_o = req;

    //////////////////////////////////////////////////////////////////////
    // retire records
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            retire_d[k].valid      = req[k];
            retire_d[k].pc         = cand_i[k].inst.pc;
            // side effects are suppressed on an exception
            retire_d[k].arf_we     = req[k] & cand_i[k].inst.w_reg & no_exc[k];
            retire_d[k].arf_id     = cand_i[k].inst.areg;
            retire_d[k].arf_data   = cand_i[k].data.data;
            retire_d[k].mem_commit = req[k] & cand_i[k].inst.w_mem & no_exc[k];
            retire_d[k].exc        = cand_i[k].data.exc;
        end
    end

    // flush shows up together with the excepting retire record
    assign flush_d = (req[0] & ~no_exc[0]) | (req[1] & ~no_exc[1]);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_q <= '0;
            flush_q  <= 1'b0;
        end else begin
            retire_q <= retire_d;
            flush_q  <= flush_d;
        end
    end

    assign retire_o = retire_q;
    assign flush_o  = flush_q;

endmodule

/* rob_top.sv */
module rob_top
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH_LOG2 = 6
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  dispatch_pkt_t [1:0]     dispatch_i,
    input  cdb_pkt_t      [1:0]     cdb_i,
    output rob_operand_t  [1:0]     operand_o,
    output logic [ROB_DEPTH_LOG2:0] rob_count_o,
    output retire_t       [1:0]     retire_o,
    output logic                    flush_o
);

    commit_cand_t [1:0] cand;
    logic         [1:0] commit_valid;
    logic         [1:0] commit_req;
    logic               flush;

    rob #(
        .ROB_DEPTH_LOG2 (ROB_DEPTH_LOG2)
    ) u_rob (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush),
        .dispatch_i     (dispatch_i),
        .cdb_i          (cdb_i),
        .commit_req_i   (commit_req),
        .operand_o      (operand_o),
        .count_o        (rob_count_o),
        .cand_o         (cand),
        .commit_valid_o (commit_valid)
    );

    // commit stage, its flush clears the rob pointers
    rob_commit u_rob_commit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .cand_i         (cand),
        .commit_valid_i (commit_valid),
        .commit_req_o   (commit_req),
        .retire_o       (retire_o),
        .flush_o        (flush)
    );

    assign flush_o = flush;

endmodule

/* tb_rob_top.sv */
module tb_rob_top
    import rob_pkg::*;
();

    localparam int DEPTH_LOG2     = 4;
    localparam int DEPTH          = 1 << DEPTH_LOG2;
    localparam int STIM_CYCLES    = 700;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    logic                clk;
    logic                arst_n;
    dispatch_pkt_t [1:0] dispatch;
    cdb_pkt_t      [1:0] cdb;
    rob_operand_t  [1:0] operand;
    logic [DEPTH_LOG2:0] rob_count;
    retire_t       [1:0] retire;
    logic                flush;

    //////////////////////////////////////////////////////////////////////
    // reference model state
    //////////////////////////////////////////////////////////////////////

    // per rob id, what the last dispatch and the last result left behind
    logic [XLEN-1:0] m_pc   [DEPTH];
    logic [XLEN-1:0] m_data [DEPTH];
    logic [4:0]      m_areg [DEPTH];
    logic [2:0]      m_exc  [DEPTH];
    bit              m_wreg [DEPTH];
    bit              m_wmem [DEPTH];
    bit              m_done [DEPTH];
    bit              m_seen [DEPTH];

    // ids in program order, oldest first
    int              order_q[$];
    // ids still waiting for a result
    int              pend_q[$];
    int              next_id;
    bit              exp_flush;
    retire_t [1:0]   exp_retire;

    int errors    = 0;
    int checks    = 0;
    int cycles    = 0;
    int n_retired = 0;
    int n_exc     = 0;
    int n_full    = 0;

    rob_top #(
        .ROB_DEPTH_LOG2 (DEPTH_LOG2)
    ) u_rob_top (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .dispatch_i  (dispatch),
        .cdb_i       (cdb),
        .operand_o   (operand),
        .rob_count_o (rob_count),
        .retire_o    (retire),
        .flush_o     (flush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("run aborted, cycle limit of %0d reached", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t %s", $time, what);
        end
    endtask

    task automatic idle_inputs();
        dispatch = '0;
        cdb      = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_inputs(input int cyc);
        int n_disp;
        int room;
        int idx;
        int id;
        int src;
        bit disp_en;
        bit cdb_en;
        bit exc_en;
        idle_inputs();
        // idle start, a stall window that fills the rob, then a drain
        disp_en = (cyc >= 8) && (cyc < STIM_CYCLES - 80);
        cdb_en  = (cyc < 30) || (cyc >= 70);
        exc_en  = (cyc >= 120);
        if (!exp_flush) begin
            room   = DEPTH - order_q.size();
            n_disp = disp_en ? int'($urandom % 3) : 0;
            if (disp_en && room == 0) begin
                n_full++;
            end
            if (n_disp > room) begin
                n_disp = room;
            end
            for (int k = 0; k < n_disp; k++) begin
                id = (next_id + k) % DEPTH;
                dispatch[k].issue    = 1'b1;
                dispatch[k].rob_id   = ROB_ID_MAX_W'(id);
                dispatch[k].kind     = inst_kind_e'($urandom % 4);
                dispatch[k].w_reg    = (dispatch[k].kind == KIND_ALU) ||
                                       (dispatch[k].kind == KIND_LOAD);
                dispatch[k].w_mem    = (dispatch[k].kind == KIND_STORE);
                dispatch[k].areg     = 5'($urandom);
                dispatch[k].pc       = $urandom & 32'hffff_fffc;
                dispatch[k].addr_imm = 16'($urandom);
                // sources point at entries already in flight
                for (int j = 0; j < 2; j++) begin
                    if (order_q.size() > 0) begin
                        src = order_q[$urandom % order_q.size()];
                    end else begin
                        src = int'($urandom % DEPTH);
                    end
                    dispatch[k].src_id[j] = ROB_ID_MAX_W'(src);
                end
            end
            // results come back in random order on both buses
            if (cdb_en) begin
                for (int b = 0; b < 2; b++) begin
                    if ((pend_q.size() > 0) && (($urandom % 4) != 0)) begin
                        idx = int'($urandom % pend_q.size());
                        id  = pend_q[idx];
                        pend_q.delete(idx);
                        cdb[b].w_valid = 1'b1;
                        cdb[b].w_preg  = ROB_ID_MAX_W'(id);
                        cdb[b].w_data  = $urandom;
                        cdb[b].exc     = EXC_NONE;
                        if (exc_en && (($urandom % 40) == 0)) begin
                            cdb[b].exc = exc_code_e'(1 + $urandom % 5);
                        end
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // model update at the clock edge
    //////////////////////////////////////////////////////////////////////

    task automatic update_model();
        bit [1:0] com;
        bit       flush_next;
        int       id;
        com        = '0;
        flush_next = 1'b0;
        exp_retire = '0;
        // in order retirement, nothing while the flush is showing
        if (!exp_flush) begin
            if ((order_q.size() > 0) && m_done[order_q[0]]) begin
                com[0] = 1'b1;
            end
            if (com[0] && (m_exc[order_q[0]] == 3'd0) && (order_q.size() > 1) &&
                m_done[order_q[1]]) begin
                com[1] = 1'b1;
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (com[k]) begin
                id = order_q[k];
                exp_retire[k].valid      = 1'b1;
                exp_retire[k].pc         = m_pc[id];
                exp_retire[k].arf_we     = m_wreg[id] && (m_exc[id] == 3'd0);
                exp_retire[k].arf_id     = m_areg[id];
                exp_retire[k].arf_data   = m_data[id];
                exp_retire[k].mem_commit = m_wmem[id] && (m_exc[id] == 3'd0);
                exp_retire[k].exc        = exc_code_e'(m_exc[id]);
                n_retired++;
                if (m_exc[id] != 3'd0) begin
                    flush_next = 1'b1;
                    n_exc++;
                end
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (com[k]) begin
                void'(order_q.pop_front());
            end
        end
        if (exp_flush) begin
            // flush drops every entry, allocation restarts at id 0
            order_q.delete();
            pend_q.delete();
            next_id = 0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (dispatch[k].issue) begin
                    id = int'(dispatch[k].rob_id) % DEPTH;
                    m_pc[id]   = dispatch[k].pc;
                    m_areg[id] = dispatch[k].areg;
                    m_wreg[id] = dispatch[k].w_reg;
                    m_wmem[id] = dispatch[k].w_mem;
                    m_done[id] = 1'b0;
                    m_seen[id] = 1'b1;
                    order_q.push_back(id);
                    pend_q.push_back(id);
                    next_id = (next_id + 1) % DEPTH;
                end
            end
            for (int b = 0; b < 2; b++) begin
                if (cdb[b].w_valid) begin
                    id = int'(cdb[b].w_preg) % DEPTH;
                    m_done[id] = 1'b1;
                    m_data[id] = cdb[b].w_data;
                    m_exc[id]  = cdb[b].exc;
                end
            end
        end
        exp_flush = flush_next;
    endtask

    //////////////////////////////////////////////////////////////////////
    // output checks, mid cycle
    //////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        int    sid;
        string tag;
        check_val("rob_count_o", XLEN'(rob_count), XLEN'(order_q.size()));
        check_val("flush_o", XLEN'(flush), XLEN'(exp_flush));
        check_true(!(retire[1].valid && !retire[0].valid),
                   "retire slot 1 valid while slot 0 is not");
        for (int k = 0; k < 2; k++) begin
            tag = $sformatf("retire_o[%0d]", k);
            check_val({tag, ".valid"}, XLEN'(retire[k].valid), XLEN'(exp_retire[k].valid));
            if (exp_retire[k].valid) begin
                check_val({tag, ".pc"}, retire[k].pc, exp_retire[k].pc);
                check_val({tag, ".arf_we"}, XLEN'(retire[k].arf_we),
                          XLEN'(exp_retire[k].arf_we));
                check_val({tag, ".arf_id"}, XLEN'(retire[k].arf_id),
                          XLEN'(exp_retire[k].arf_id));
                check_val({tag, ".arf_data"}, retire[k].arf_data, exp_retire[k].arf_data);
                check_val({tag, ".mem_commit"}, XLEN'(retire[k].mem_commit),
                          XLEN'(exp_retire[k].mem_commit));
                check_val({tag, ".exc"}, XLEN'(retire[k].exc), XLEN'(exp_retire[k].exc));
            end
        end
        // operands reflect results written before this cycle
        for (int k = 0; k < 2; k++) begin
            if (dispatch[k].issue) begin
                for (int j = 0; j < 2; j++) begin
                    sid = int'(dispatch[k].src_id[j]) % DEPTH;
                    tag = $sformatf("operand_o[%0d]", k);
                    if (m_seen[sid]) begin
                        check_val($sformatf("%s.done[%0d]", tag, j),
                                  XLEN'(operand[k].done[j]), XLEN'(m_done[sid]));
                        if (m_done[sid]) begin
                            check_val($sformatf("%s.data[%0d]", tag, j),
                                      operand[k].data[j], m_data[sid]);
                        end
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h9eab));
        idle_inputs();
        arst_n     = 1'b0;
        next_id    = 0;
        exp_flush  = 1'b0;
        exp_retire = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            drive_inputs(cyc);
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            update_model();
            #1;
        end
        idle_inputs();

        check_true(order_q.size() == 0, "ROB still holds entries after the drain phase");
        check_true(n_full > 0, "the ROB never filled up, dispatch was never held back");
        check_true(n_exc > 0, "no instruction with an exception was retired");
        check_true(n_retired > 200, "too few instructions retired");

        $display("checks %0d, errors %0d, retired %0d, exceptions %0d, full cycles %0d",
                 checks, errors, n_retired, n_exc, n_full);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* rob_top.f */
rob_pkg.sv
rob_regfile.sv
rob_done_table.sv
rob.sv
rob_commit.sv
rob_top.sv
tb_rob_top.sv

/* Bender.yml */
package:
  name: rob_top

sources:
  - rob_pkg.sv
  - rob_regfile.sv
  - rob_done_table.sv
  - rob.sv
  - rob_commit.sv
  - rob_top.sv
  - target: test
    files:
      - tb_rob_top.sv
